/* common/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// first fetch address out of reset
`define CPU_START_PC 32'h100

// byte step between consecutive instructions
`define CPU_INST_BYTES 4

// data memory depth in words
// the word index is taken from address bits above the byte offset
`define CPU_DMEM_WORDS 1024

// memory-mapped key register, reads as the inverted key pins
`define CPU_ADDR_KEY 32'hFFFFF080

// number of key pins
`define CPU_KEY_BITS 4

`endif

/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;
  // 16 registers, r0 reads as zero
  typedef logic [3:0] regno_t;

  // primary opcode, bits 31:26
  typedef enum logic [5:0] {
    OP1_ALUR = 6'b000000,
    OP1_BEQ  = 6'b001000,
    OP1_BLT  = 6'b001001,
    OP1_BLE  = 6'b001010,
    OP1_BNE  = 6'b001011,
    OP1_JAL  = 6'b001100,
    OP1_LW   = 6'b010010,
    OP1_SW   = 6'b011010,
    OP1_ADDI = 6'b100000,
    OP1_ANDI = 6'b100100,
    OP1_ORI  = 6'b100101,
    OP1_XORI = 6'b100110
  } op1_e;

  // alu function for OP1_ALUR, bits 25:18
  typedef enum logic [7:0] {
    OP2_EQ   = 8'b00001000,
    OP2_LT   = 8'b00001001,
    OP2_LE   = 8'b00001010,
    OP2_NE   = 8'b00001011,
    OP2_ADD  = 8'b00100000,
    OP2_AND  = 8'b00100100,
    OP2_OR   = 8'b00100101,
    OP2_XOR  = 8'b00100110,
    OP2_SUB  = 8'b00101000,
    OP2_NAND = 8'b00101100,
    OP2_NOR  = 8'b00101101,
    OP2_NXOR = 8'b00101110,
    OP2_RSHF = 8'b00110000,
    OP2_LSHF = 8'b00110001
  } op2_e;

  // register-register layout
  typedef struct packed {
    op1_e       op1;
    op2_e       op2;
    logic [5:0] spare;
    regno_t     rd;
    regno_t     rs;
    regno_t     rt;
  } alur_fmt_t;

  // immediate layout, also used by branches, jal and memory ops
  typedef struct packed {
    op1_e        op1;
    logic [1:0]  spare;
    logic [15:0] imm16;
    regno_t      rs;
    regno_t      rt;
  } imm_fmt_t;

  // same instruction word, two decodings
  typedef union packed {
    alur_fmt_t alur_fmt;
    imm_fmt_t  imm_fmt;
  } inst_u;

  typedef struct packed {
    logic is_br;
    logic is_jmp;
    logic rd_mem;
    logic wr_mem;
    logic wr_reg;
    logic valid;
  } ctrl_t;

  // decode -> execute
  typedef struct packed {
    word_t  pc;
    word_t  rs_val;
    word_t  rt_val;
    word_t  imm;
    op1_e   op1;
    op2_e   op2;
    regno_t dst;
    ctrl_t  ctrl;
  } id_ex_t;

  // execute -> memory
  typedef struct packed {
    word_t  result;
    word_t  store_data;
    regno_t dst;
    logic   rd_mem;
    logic   wr_mem;
    logic   wr_reg;
    logic   valid;
  } ex_mem_t;

  // memory -> register file write
  typedef struct packed {
    logic   we;
    regno_t dst;
    word_t  value;
  } wb_t;

  // external store bus, one store per clock with we high
  typedef struct packed {
    logic  we;
    word_t addr;
    word_t data;
  } store_t;

endpackage

`default_nettype wire

/* rtl/fetch_stage.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_settings.svh"

module fetch_stage (
  input  wire logic           clk,
  input  wire logic           reset,
  input  wire logic           stall,
  input  wire logic           redirect,
  input  wire cpu_pkg::word_t redirect_pc,
  input  wire cpu_pkg::inst_u inst,
  output      cpu_pkg::word_t imem_addr,
  output      cpu_pkg::inst_u if_inst,
  output      cpu_pkg::word_t if_pc,
  output      logic           if_valid
);

  cpu_pkg::word_t pc;

  // redirect beats stall, no prediction beyond pc + 4
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= `CPU_START_PC;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (!stall) begin
      pc <= pc + `CPU_INST_BYTES;
    end
  end

  // instruction comes back in the same cycle
  assign imem_addr = pc;

  // fetch latch, held on stall, bubble on redirect
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      if_inst  <= '0;
      if_pc    <= '0;
      if_valid <= 1'b0;
    end else if (redirect) begin
      if_valid <= 1'b0;
    end else if (!stall) begin
      if_inst  <= inst;
      if_pc    <= pc;
      if_valid <= 1'b1;
    end
  end

  // targets from execute must keep the pc on a word boundary
  a_pc_aligned : assert property (@(posedge clk) disable iff (reset)
    redirect |=> pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire cpu_pkg::inst_u   if_inst,
  input  wire cpu_pkg::word_t   if_pc,
  input  wire logic             if_valid,
  input  wire logic             redirect,
  input  wire cpu_pkg::word_t   ex_fwd,
  input  wire cpu_pkg::word_t   mem_fwd,
  input  wire cpu_pkg::ex_mem_t ex_mem,
  input  wire cpu_pkg::wb_t     wb,
  output      logic             stall,
  output      cpu_pkg::id_ex_t  id_ex
);

  cpu_pkg::op1_e   op1;
  cpu_pkg::op2_e   op2;
  cpu_pkg::regno_t rs;
  cpu_pkg::regno_t rt;
  cpu_pkg::regno_t dst;
  cpu_pkg::ctrl_t  dec_ctrl;
  cpu_pkg::id_ex_t id_ex_d;
  logic            wr_any;
  cpu_pkg::word_t  regs [16];

  // operand priority: execute, memory, write-back, then the file
  // r0 never matches since no stage carries a write to it
  function automatic cpu_pkg::word_t pick_operand(cpu_pkg::regno_t src);
    if (src == '0) return '0;
    if (id_ex.ctrl.wr_reg && id_ex.dst == src) return ex_fwd;
    if (ex_mem.wr_reg && ex_mem.dst == src) return mem_fwd;
    if (wb.we && wb.dst == src) return wb.value;
    return regs[src];
  endfunction

  assign op1 = if_inst.alur_fmt.op1;
  assign op2 = if_inst.alur_fmt.op2;
  assign rs  = if_inst.imm_fmt.rs;
  assign rt  = if_inst.imm_fmt.rt;

  // write-back port, read side sees it through pick_operand
  always_ff @(posedge clk) begin
    if (wb.we) begin
      regs[wb.dst] <= wb.value;
    end
  end

  always_comb begin
    dec_ctrl = '0;
    wr_any   = 1'b0;
    // immediate types, loads and jal write rt
    dst      = rt;
    case (op1)
      cpu_pkg::OP1_ALUR: begin
        dst    = if_inst.alur_fmt.rd;
        wr_any = op2 inside {cpu_pkg::OP2_EQ, cpu_pkg::OP2_LT, cpu_pkg::OP2_LE,
                             cpu_pkg::OP2_NE, cpu_pkg::OP2_ADD, cpu_pkg::OP2_AND,
                             cpu_pkg::OP2_OR, cpu_pkg::OP2_XOR, cpu_pkg::OP2_SUB,
                             cpu_pkg::OP2_NAND, cpu_pkg::OP2_NOR, cpu_pkg::OP2_NXOR,
                             cpu_pkg::OP2_RSHF, cpu_pkg::OP2_LSHF};
      end
      cpu_pkg::OP1_BEQ, cpu_pkg::OP1_BLT, cpu_pkg::OP1_BLE, cpu_pkg::OP1_BNE: begin
        dec_ctrl.is_br = 1'b1;
      end
      cpu_pkg::OP1_JAL: begin
        dec_ctrl.is_jmp = 1'b1;
        wr_any          = 1'b1;
      end
      cpu_pkg::OP1_LW: begin
        dec_ctrl.rd_mem = 1'b1;
        wr_any          = 1'b1;
      end
      cpu_pkg::OP1_SW: begin
        dec_ctrl.wr_mem = 1'b1;
      end
      cpu_pkg::OP1_ADDI, cpu_pkg::OP1_ANDI, cpu_pkg::OP1_ORI, cpu_pkg::OP1_XORI: begin
        wr_any = 1'b1;
      end
      default: begin
        wr_any = 1'b0;
      end
    endcase
    // writes to r0 are dropped here
    dec_ctrl.wr_reg = wr_any && (dst != '0);
    dec_ctrl.valid  = 1'b1;
  end

  // load in execute feeding a source here, wait one cycle
  assign stall = if_valid && id_ex.ctrl.rd_mem && id_ex.ctrl.wr_reg &&
                 (id_ex.dst == rs || id_ex.dst == rt);

  always_comb begin
    id_ex_d.pc     = if_pc;
    id_ex_d.rs_val = pick_operand(rs);
    id_ex_d.rt_val = pick_operand(rt);
    id_ex_d.imm    = {{16{if_inst.imm_fmt.imm16[15]}}, if_inst.imm_fmt.imm16};
    id_ex_d.op1    = op1;
    id_ex_d.op2    = op2;
    id_ex_d.dst    = dst;
    // bubble on flush, stall or empty fetch latch
    id_ex_d.ctrl   = (redirect || stall || !if_valid) ? '0 : dec_ctrl;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id_ex <= '0;
    end else begin
      id_ex <= id_ex_d;
    end
  end

  // the stalled instruction must still sit in the fetch latch for its retry
  a_load_use : assert property (@(posedge clk) disable iff (reset)
    stall |=> $stable(if_inst) && $stable(if_pc));

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_settings.svh"

module execute_stage (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire cpu_pkg::id_ex_t  id_ex,
  output      cpu_pkg::word_t   ex_fwd,
  output      logic             redirect,
  output      cpu_pkg::word_t   redirect_pc,
  output      cpu_pkg::ex_mem_t ex_mem
);

  cpu_pkg::word_t   a;
  cpu_pkg::word_t   b;
  cpu_pkg::word_t   imm_x4;
  cpu_pkg::word_t   result;
  cpu_pkg::word_t   target;
  cpu_pkg::ex_mem_t ex_mem_d;
  logic             br_cond;
  logic             taken;

  assign a      = id_ex.rs_val;
  assign b      = id_ex.rt_val;
  assign imm_x4 = {id_ex.imm[29:0], 2'b00};

  always_comb begin
    case (id_ex.op1)
      cpu_pkg::OP1_ALUR: begin
        case (id_ex.op2)
          // comparisons are signed
          cpu_pkg::OP2_EQ:   result = {31'b0, a == b};
          cpu_pkg::OP2_LT:   result = {31'b0, $signed(a) < $signed(b)};
          cpu_pkg::OP2_LE:   result = {31'b0, $signed(a) <= $signed(b)};
          cpu_pkg::OP2_NE:   result = {31'b0, a != b};
          cpu_pkg::OP2_ADD:  result = a + b;
          cpu_pkg::OP2_AND:  result = a & b;
          cpu_pkg::OP2_OR:   result = a | b;
          cpu_pkg::OP2_XOR:  result = a ^ b;
          cpu_pkg::OP2_SUB:  result = a - b;
          cpu_pkg::OP2_NAND: result = ~(a & b);
          cpu_pkg::OP2_NOR:  result = ~(a | b);
          cpu_pkg::OP2_NXOR: result = ~(a ^ b);
          // logical shifts by the low five bits of rt
          cpu_pkg::OP2_RSHF: result = a >> b[4:0];
          cpu_pkg::OP2_LSHF: result = a << b[4:0];
          default:           result = '0;
        endcase
      end
      // address or sum
      cpu_pkg::OP1_LW, cpu_pkg::OP1_SW, cpu_pkg::OP1_ADDI: result = a + id_ex.imm;
      cpu_pkg::OP1_ANDI: result = a & id_ex.imm;
      cpu_pkg::OP1_ORI:  result = a | id_ex.imm;
      cpu_pkg::OP1_XORI: result = a ^ id_ex.imm;
      // link value
      cpu_pkg::OP1_JAL:  result = id_ex.pc + `CPU_INST_BYTES;
      default:           result = '0;
    endcase
  end

  always_comb begin
    case (id_ex.op1)
      cpu_pkg::OP1_BEQ: br_cond = a == b;
      cpu_pkg::OP1_BLT: br_cond = $signed(a) < $signed(b);
      cpu_pkg::OP1_BLE: br_cond = $signed(a) <= $signed(b);
      cpu_pkg::OP1_BNE: br_cond = a != b;
      default:          br_cond = 1'b0;
    endcase
  end

  // jal goes through rs, branches are pc relative from pc + 4
  assign target = id_ex.ctrl.is_jmp ? a + imm_x4 : id_ex.pc + `CPU_INST_BYTES + imm_x4;
  // the instruction behind a taken branch is wrong path and cannot redirect
  assign taken  = id_ex.ctrl.valid && !redirect &&
                  (id_ex.ctrl.is_jmp || (id_ex.ctrl.is_br && br_cond));
  assign ex_fwd = result;

  always_comb begin
    ex_mem_d.result     = result;
    ex_mem_d.store_data = b;
    ex_mem_d.dst        = id_ex.dst;
    ex_mem_d.rd_mem     = id_ex.ctrl.rd_mem;
    ex_mem_d.wr_mem     = id_ex.ctrl.wr_mem;
    ex_mem_d.wr_reg     = id_ex.ctrl.wr_reg;
    ex_mem_d.valid      = id_ex.ctrl.valid;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      redirect    <= 1'b0;
      redirect_pc <= '0;
      ex_mem      <= '0;
    end else begin
      redirect    <= taken;
      redirect_pc <= target;
      // flush cycle squashes what sits in execute
      ex_mem      <= redirect ? '0 : ex_mem_d;
    end
  end

  // decode squashes its slot in the flush cycle, so execute sees a bubble next
  a_one_redirect : assert property (@(posedge clk) disable iff (reset)
    redirect |=> !id_ex.ctrl.valid);

endmodule

`default_nettype wire

/* rtl/memory_stage.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_settings.svh"

module memory_stage (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire cpu_pkg::ex_mem_t         ex_mem,
  input  wire logic [`CPU_KEY_BITS-1:0] keys,
  output      cpu_pkg::word_t           mem_fwd,
  output      cpu_pkg::store_t          io_wr,
  output      cpu_pkg::wb_t             wb
);

  localparam int IDX_W = $clog2(`CPU_DMEM_WORDS);

  cpu_pkg::word_t   dmem [`CPU_DMEM_WORDS];
  logic [IDX_W-1:0] idx;
  cpu_pkg::word_t   load_val;

  // word index, upper address bits wrap
  assign idx = ex_mem.result[IDX_W+1:2];

  // key register answers at its own address, pins are active low
  assign load_val = (ex_mem.result == `CPU_ADDR_KEY) ?
                    {{(32 - `CPU_KEY_BITS){1'b0}}, ~keys} : dmem[idx];

  // load data or alu result, also the forwarding tap
  assign mem_fwd = ex_mem.rd_mem ? load_val : ex_mem.result;

  // every store shows on the bus for exactly its memory cycle
  assign io_wr.we   = ex_mem.wr_mem && ex_mem.valid;
  assign io_wr.addr = ex_mem.result;
  assign io_wr.data = ex_mem.store_data;

  always_ff @(posedge clk) begin
    if (io_wr.we) begin
      dmem[idx] <= ex_mem.store_data;
    end
  end

  // write-back latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb <= '0;
    end else begin
      wb.we    <= ex_mem.wr_reg && ex_mem.valid;
      wb.dst   <= ex_mem.dst;
      wb.value <= mem_fwd;
    end
  end

  a_store_aligned : assert property (@(posedge clk) disable iff (reset)
    io_wr.we |-> io_wr.addr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* rtl/cpu_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_settings.svh"

module cpu_top (
  input  wire  logic                     clk,
  input  wire  logic                     reset,
  output       cpu_pkg::word_t           imem_addr,
  input  wire  cpu_pkg::inst_u           inst,
  input  wire  logic [`CPU_KEY_BITS-1:0] keys,
  output       cpu_pkg::store_t          io_wr
);

  // hazard and redirect
  logic            stall;
  logic            redirect;
  cpu_pkg::word_t  redirect_pc;

  // fetch latch
  cpu_pkg::inst_u  if_inst;
  cpu_pkg::word_t  if_pc;
  logic            if_valid;

  // later stages, plus their forwarding taps
  cpu_pkg::id_ex_t  id_ex;
  cpu_pkg::word_t   ex_fwd;
  cpu_pkg::ex_mem_t ex_mem;
  cpu_pkg::word_t   mem_fwd;
  cpu_pkg::wb_t     wb;

  fetch_stage fetch0 (
    .clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
    .redirect_pc(redirect_pc), .inst(inst), .imem_addr(imem_addr),
    .if_inst(if_inst), .if_pc(if_pc), .if_valid(if_valid)
  );

  decode_stage decode0 (
    .clk(clk), .reset(reset), .if_inst(if_inst), .if_pc(if_pc), .if_valid(if_valid),
    .redirect(redirect), .ex_fwd(ex_fwd), .mem_fwd(mem_fwd), .ex_mem(ex_mem),
    .wb(wb), .stall(stall), .id_ex(id_ex)
  );

  execute_stage execute0 (
    .clk(clk), .reset(reset), .id_ex(id_ex), .ex_fwd(ex_fwd),
    .redirect(redirect), .redirect_pc(redirect_pc), .ex_mem(ex_mem)
  );

  memory_stage memory0 (
    .clk(clk), .reset(reset), .ex_mem(ex_mem), .keys(keys),
    .mem_fwd(mem_fwd), .io_wr(io_wr), .wb(wb)
  );

endmodule

`default_nettype wire

/* tests/isa_model.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// sequential reference state, one instruction at a time
cpu_pkg::word_t m_regs [16];
cpu_pkg::word_t m_mem [`CPU_DMEM_WORDS];
// expected store bus traffic, in program order
cpu_pkg::word_t exp_addr [$];
cpu_pkg::word_t exp_data [$];

function automatic cpu_pkg::word_t alu_ref(input logic [7:0] fn, input cpu_pkg::word_t x,
                                           input cpu_pkg::word_t y);
  case (fn)
    cpu_pkg::OP2_EQ:   return {31'b0, x == y};
    cpu_pkg::OP2_LT:   return {31'b0, $signed(x) < $signed(y)};
    cpu_pkg::OP2_LE:   return {31'b0, $signed(x) <= $signed(y)};
    cpu_pkg::OP2_NE:   return {31'b0, x != y};
    cpu_pkg::OP2_ADD:  return x + y;
    cpu_pkg::OP2_AND:  return x & y;
    cpu_pkg::OP2_OR:   return x | y;
    cpu_pkg::OP2_XOR:  return x ^ y;
    cpu_pkg::OP2_SUB:  return x - y;
    cpu_pkg::OP2_NAND: return ~(x & y);
    cpu_pkg::OP2_NOR:  return ~(x | y);
    cpu_pkg::OP2_NXOR: return ~(x ^ y);
    // shift amount is the low five bits of rt
    cpu_pkg::OP2_RSHF: return x >> y[4:0];
    cpu_pkg::OP2_LSHF: return x << y[4:0];
    default:           return '0;
  endcase
endfunction

function automatic logic br_ref(input logic [5:0] op, input cpu_pkg::word_t x,
                                input cpu_pkg::word_t y);
  case (op)
    cpu_pkg::OP1_BEQ: return x == y;
    cpu_pkg::OP1_BLT: return $signed(x) < $signed(y);
    cpu_pkg::OP1_BLE: return $signed(x) <= $signed(y);
    cpu_pkg::OP1_BNE: return x != y;
    default:          return 1'b0;
  endcase
endfunction

// walks prog[] from the start pc until the final self loop
task automatic run_model(input logic [`CPU_KEY_BITS-1:0] key_pins);
  cpu_pkg::word_t pc;
  cpu_pkg::word_t w;
  cpu_pkg::word_t a;
  cpu_pkg::word_t b;
  cpu_pkg::word_t simm;
  cpu_pkg::word_t addr;
  cpu_pkg::word_t res;
  cpu_pkg::regno_t dst;
  logic wr;
  int steps;
  exp_addr.delete();
  exp_data.delete();
  for (int r = 0; r < 16; r++) begin
    m_regs[r] = '0;
  end
  pc = `CPU_START_PC;
  steps = 0;
  while (pc != loop_pc && steps < PROG_MAX * 4) begin
    w = prog[(pc - `CPU_START_PC) >> 2];
    a = m_regs[w[7:4]];
    b = m_regs[w[3:0]];
    // imm16 sits in bits 23:8
    simm = {{16{w[23]}}, w[23:8]};
    addr = a + simm;
    res = '0;
    wr = 1'b1;
    dst = w[3:0];
    // from here pc is the own pc plus 4, which is also the jal link
    pc = pc + `CPU_INST_BYTES;
    case (w[31:26])
      cpu_pkg::OP1_ALUR: begin
        res = alu_ref(w[25:18], a, b);
        dst = w[11:8];
      end
      cpu_pkg::OP1_ADDI: res = addr;
      cpu_pkg::OP1_ANDI: res = a & simm;
      cpu_pkg::OP1_ORI:  res = a | simm;
      cpu_pkg::OP1_XORI: res = a ^ simm;
      cpu_pkg::OP1_LW: begin
        if (addr == `CPU_ADDR_KEY) begin
          res = {{(32 - `CPU_KEY_BITS){1'b0}}, ~key_pins};
        end else begin
          res = m_mem[(addr >> 2) % `CPU_DMEM_WORDS];
        end
      end
      cpu_pkg::OP1_SW: begin
        wr = 1'b0;
        m_mem[(addr >> 2) % `CPU_DMEM_WORDS] = b;
        exp_addr.push_back(addr);
        exp_data.push_back(b);
      end
      cpu_pkg::OP1_JAL: begin
        res = pc;
        pc = a + (simm << 2);
      end
      default: begin
        wr = 1'b0;
        if (br_ref(w[31:26], a, b)) begin
          pc = pc + (simm << 2);
        end
      end
    endcase
    // r0 stays zero
    if (wr && dst != 0) begin
      m_regs[dst] = res;
    end
    steps = steps + 1;
  end
endtask

`endif

/* tests/cpu_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_settings.svh"

module cpu_tb;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_TESTS  = 8;
  localparam int PROG_MAX   = 64;
  // 15 register setup words plus the random body
  localparam int BODY_END   = 40;
  localparam logic [14*8-1:0] ALU_OPS = {
    cpu_pkg::OP2_EQ, cpu_pkg::OP2_LT, cpu_pkg::OP2_LE, cpu_pkg::OP2_NE, cpu_pkg::OP2_ADD,
    cpu_pkg::OP2_AND, cpu_pkg::OP2_OR, cpu_pkg::OP2_XOR, cpu_pkg::OP2_SUB, cpu_pkg::OP2_NAND,
    cpu_pkg::OP2_NOR, cpu_pkg::OP2_NXOR, cpu_pkg::OP2_RSHF, cpu_pkg::OP2_LSHF};
  localparam logic [4*6-1:0] IMM_OPS = {
    cpu_pkg::OP1_ADDI, cpu_pkg::OP1_ANDI, cpu_pkg::OP1_ORI, cpu_pkg::OP1_XORI};
  localparam logic [4*6-1:0] BR_OPS = {
    cpu_pkg::OP1_BEQ, cpu_pkg::OP1_BLT, cpu_pkg::OP1_BLE, cpu_pkg::OP1_BNE};

  logic                     clk;
  logic                     reset;
  cpu_pkg::word_t           imem_addr;
  cpu_pkg::inst_u           inst;
  logic [`CPU_KEY_BITS-1:0] keys;
  cpu_pkg::store_t          io_wr;

  // program image, loop_pc is the final self loop
  cpu_pkg::word_t prog [PROG_MAX];
  cpu_pkg::word_t loop_pc;
  cpu_pkg::word_t imem_idx;
  integer         seed;
  int             fill;
  int             got;
  int             errors;
  int             bad_tests;
  logic           checking;

  `include "isa_model.svh"

  cpu_top dut0 (
    .clk(clk), .reset(reset), .imem_addr(imem_addr), .inst(inst), .keys(keys), .io_wr(io_wr)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // fetch port, anything outside the image reads as an inert zero word
  assign imem_idx = (imem_addr - `CPU_START_PC) >> 2;
  assign inst     = (imem_idx < PROG_MAX) ? prog[imem_idx] : '0;

  function automatic int rnd(input int n);
    return ($random(seed) & 32'h7fffffff) % n;
  endfunction

  function automatic cpu_pkg::word_t encode_alur(input logic [7:0] fn, input logic [3:0] rd,
                                                 input logic [3:0] rs, input logic [3:0] rt);
    return {cpu_pkg::OP1_ALUR, fn, 6'b0, rd, rs, rt};
  endfunction

  function automatic cpu_pkg::word_t encode_imm(input logic [5:0] op, input logic [15:0] imm,
                                                input logic [3:0] rs, input logic [3:0] rt);
    return {op, 2'b00, imm, rs, rt};
  endfunction

  task automatic put_word(input cpu_pkg::word_t w);
    prog[fill] = w;
    fill = fill + 1;
  endtask

  // kind 0 alu, 1 immediates, 2 short chains, 3 memory, 4 branches, 5 keys, 6+ mixed
  task automatic build_program(input int kind);
    int cls;
    int pool;
    logic [3:0] x;
    logic [3:0] y;
    // a tiny register pool forces dependencies at distance 1 to 3
    pool = (kind == 2) ? 3 : 7;
    for (int j = 0; j < PROG_MAX; j++) begin
      prog[j] = '0;
    end
    fill = 0;
    // register file has no reset, so every register gets a value first
    for (int r = 1; r < 16; r++) begin
      put_word(encode_imm(cpu_pkg::OP1_ADDI, $random(seed), 4'd0, r));
    end
    while (fill < BODY_END) begin
      cls = (kind >= 6) ? rnd(6) : kind;
      if (cls == 2) begin
        cls = rnd(2);
      end
      x = 1 + rnd(pool);
      y = 1 + rnd(pool);
      case (cls)
        0: put_word(encode_alur(ALU_OPS[8*rnd(14) +: 8], x, y, 1 + rnd(pool)));
        1: put_word(encode_imm(IMM_OPS[6*rnd(4) +: 6], $random(seed), y, x));
        3: begin
          // store, reload, and use the load right away
          put_word(encode_imm(cpu_pkg::OP1_SW, 16'h200 + 4 * rnd(8), 4'd0, x));
          put_word(encode_imm(cpu_pkg::OP1_LW, prog[fill-1][23:8], 4'd0, y));
          put_word(encode_alur(cpu_pkg::OP2_ADD, x, y, y));
        end
        4: begin
          // forward only, skip 0 to 2 words
          if (rnd(2) == 1) begin
            put_word(encode_imm(BR_OPS[6*rnd(4) +: 6], rnd(3), x, y));
          end else begin
            put_word(encode_imm(cpu_pkg::OP1_JAL, (`CPU_START_PC >> 2) + fill + 1 + rnd(3),
                                4'd0, x));
          end
        end
        default: begin
          put_word(encode_imm(cpu_pkg::OP1_LW, `CPU_ADDR_KEY, 4'd0, x));
          put_word(encode_imm(cpu_pkg::OP1_SW, 16'h300, 4'd0, x));
        end
      endcase
    end
    // dump r1..r15, then park on BEQ r0,r0,-1
    for (int r = 1; r < 16; r++) begin
      put_word(encode_imm(cpu_pkg::OP1_SW, 16'h400 + 4 * (r - 1), 4'd0, r));
    end
    loop_pc = `CPU_START_PC + 4 * fill;
    put_word(encode_imm(cpu_pkg::OP1_BEQ, 16'hFFFF, 4'd0, 4'd0));
  endtask

  // store bus monitor, each store is on the bus for one full cycle
  always @(negedge clk) begin
    if (checking && io_wr.we) begin
      if (got >= exp_addr.size()) begin
        $display("ERR %0t: extra store addr %h data %h", $time, io_wr.addr, io_wr.data);
        errors = errors + 1;
      end else if (io_wr.addr !== exp_addr[got] || io_wr.data !== exp_data[got]) begin
        $display("ERR %0t: store %0d addr %h data %h, expected addr %h data %h", $time, got,
                 io_wr.addr, io_wr.data, exp_addr[got], exp_data[got]);
        errors = errors + 1;
      end
      got = got + 1;
    end
  end

  task automatic run_test(input int kind, input string name);
    int cycles;
    int errs_before;
    @(negedge clk);
    checking = 1'b0;
    reset = 1'b1;
    keys = $random(seed);
    build_program(kind);
    run_model(keys);
    repeat (4) @(negedge clk);
    got = 0;
    errs_before = errors;
    reset = 1'b0;
    checking = 1'b1;
    cycles = 0;
    while (got < exp_addr.size() && cycles < PROG_MAX * 10) begin
      @(negedge clk);
      cycles = cycles + 1;
    end
    // a short drain so stray stores after the last one still show up
    repeat (8) @(negedge clk);
    if (got < exp_addr.size()) begin
      $display("test %0d %s: only %0d of %0d expected stores appeared on the bus", kind, name,
               got, exp_addr.size());
      errors = errors + 1;
    end
    $display("test %0d %s: %0d stores seen, %0d errors", kind, name, got, errors - errs_before);
    if (errors != errs_before) begin
      bad_tests = bad_tests + 1;
    end
  endtask

  // 20 cycles per program word per test, plus reset
  initial begin
    #((PROG_MAX * 20 + 10) * NUM_TESTS * CLK_PERIOD);
    $display("watchdog expired, the tests did not finish in time");
    $display("Test failed");
    $finish;
  end

  initial begin
    seed = 32'h27fd;
    clk = 1'b0;
    reset = 1'b1;
    keys = '0;
    checking = 1'b0;
    got = 0;
    errors = 0;
    bad_tests = 0;
    run_test(0, "alu");
    run_test(1, "immediates");
    run_test(2, "chains");
    run_test(3, "memory");
    run_test(4, "branches");
    run_test(5, "keys");
    run_test(6, "mixed");
    run_test(7, "mixed");
    $display("tests %0d, failing tests %0d, errors %0d", NUM_TESTS, bad_tests, errors);
    if (bad_tests == 0 && errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cpu_top.f */
+incdir+common
+incdir+tests
common/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_top.sv
tests/cpu_tb.sv
